// ==== logic/hangmanPkg.sv ====
// Shared definitions for the five-letter hangman core.
// Characters are raw bytes. There is no case folding and no range check,
// so any byte value counts as a letter.
// Display rows are 16 characters with the leftmost character in the top byte.
package hangmanPkg;

    // ########################################################################
    // game and display constants
    // ########################################################################
    localparam int wordLen     = 5;    // letters per secret word.
    localparam int maxMistakes = 6;    // this many misses ends the game.
    localparam int lcdCols     = 16;   // characters per display row.
    localparam int wordCol     = 5;    // first column of the word on either row.
    localparam int missCol     = 5;    // newest miss sits here, older ones to the right.
    localparam int msgCol      = 6;    // first column of "Win" or "Lose".

    typedef logic [7:0] char_t;
    typedef char_t [0:lcdCols-1] lcdRow_t;  // element 0 is the leftmost column.

    localparam char_t charSpace = 8'h20;
    localparam char_t charBlank = 8'h5F;    // underscore.

    localparam char_t [0:2] winText  = "Win";
    localparam char_t [0:3] loseText = "Lose";

    // ########################################################################
    // state and bus types
    // ########################################################################
    typedef enum logic [1:0] {
        IDLE,
        PLAYING,
        WON,
        LOST
    } gameState_e;

    typedef struct packed {
        logic                  load;
        char_t [0:wordLen-1]   word;    // position 0 in the top byte.
    } wordLoad_t;

    typedef struct packed {
        logic  valid;
        char_t letter;
    } guessBeat_t;

    typedef struct packed {
        gameState_e           state;
        logic [wordLen-1:0]   revealed;     // bit i is word position i.
        logic [2:0]           numMistake;
    } roundStatus_t;

    typedef struct packed {
        logic  valid;
        char_t letter;
    } missBeat_t;

endpackage

// ==== logic/guessIntake.sv ====
// Registers the host strobes into beats that go out to every slot.
// A guess is only passed on while a game runs, or while a word load is
// already in flight and is about to start one. A load and a guess in the
// same cycle keep the load and lose the guess.
`timescale 1ns/10ps

module guessIntake import hangmanPkg::*; (
    input  logic                clk,
    input  logic                nRst,
    input  logic                loadWord,
    input  char_t [0:wordLen-1] word,
    input  logic                guessStrobe,
    input  char_t               guess,
    input  roundStatus_t        status,
    output wordLoad_t           wordBus,
    output guessBeat_t          guessBus
);
    logic                loadQ;
    logic                validQ;
    char_t [0:wordLen-1] wordQ;
    char_t               letterQ;
    logic                accept;

    // the judge only reaches PLAYING one cycle after loadQ, so a pending load counts too.
    assign accept = guessStrobe && !loadWord && (status.state == PLAYING || loadQ);

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            loadQ  <= 1'b0;
            validQ <= 1'b0;
        end else begin
            loadQ  <= loadWord;
            validQ <= accept;
        end
    end

    always_ff @(posedge clk) begin
        wordQ   <= word;
        letterQ <= guess;
    end

    assign wordBus  = '{load: loadQ, word: wordQ};
    assign guessBus = '{valid: validQ, letter: letterQ};

    // a guess taken behind a pending load is only judged if that load starts a game.
    assert property (@(posedge clk) disable iff (!nRst)
        wordBus.load |=> (status.state == PLAYING))
    else $error("guessIntake: load in flight did not start a game");

endmodule

// ==== logic/letterSlot.sv ====
// One position of the secret word.
// The character comes in on its own port. The top level picks the byte,
// and the slot latches it whenever the word bus carries a load.
// A repeat guess of a revealed letter does not hit, so the judge counts it as a miss.
`timescale 1ns/10ps

module letterSlot import hangmanPkg::*; (
    input  logic       clk,
    input  logic       nRst,
    input  wordLoad_t  wordBus,
    input  guessBeat_t guessBus,
    input  char_t      secret,
    output logic       hit,
    output logic       revealed
);
    char_t storedChar;

    always_ff @(posedge clk) begin
        if (wordBus.load) begin
            storedChar <= secret;
        end
    end

    // hit is combinational so the judge sees it in the same cycle as the guess.
    assign hit = guessBus.valid && (guessBus.letter == storedChar) && !revealed;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            revealed <= 1'b0;
        end else if (wordBus.load) begin
            revealed <= 1'b0;   // new word, everything hidden again.
        end else if (hit) begin
            revealed <= 1'b1;
        end
    end

    // a load in the same beat would clear the slot and lose the reveal of this hit.
    assert property (@(posedge clk) disable iff (!nRst)
        hit |-> !wordBus.load)
    else $error("letterSlot: hit in the same beat as a load");

endmodule

// ==== logic/roundJudge.sv ====
// Game state machine and mistake counter.
// A guess that hits no slot is a miss and is reported on the miss beat.
// Win is decided from the revealed mask together with this cycle's hits.
// Guesses that slip in after the game has ended are ignored here.
`timescale 1ns/10ps

module roundJudge import hangmanPkg::*; (
    input  logic               clk,
    input  logic               nRst,
    input  wordLoad_t          wordBus,
    input  guessBeat_t         guessBus,
    input  logic [wordLen-1:0] hit,
    input  logic [wordLen-1:0] revealed,
    output roundStatus_t       status,
    output missBeat_t          miss
);
    gameState_e state;
    gameState_e nextState;
    logic [2:0] numMistake;
    logic [2:0] nextMistake;
    logic       missValid;
    logic       nextMissValid;
    char_t      missLetter;
    logic       anyHit;
    logic       allRevealed;

    assign anyHit      = |hit;
    assign allRevealed = &(revealed | hit);    // the hits land in revealed at the next edge.

    // ########################################################################
    // next state
    // ########################################################################
    always_comb begin
        nextState     = state;
        nextMistake   = numMistake;
        nextMissValid = 1'b0;
        if (wordBus.load) begin
            nextState   = PLAYING;   // a load restarts from any state.
            nextMistake = '0;
        end else if (state == PLAYING && guessBus.valid) begin
            if (anyHit) begin
                if (allRevealed) begin
                    nextState = WON;
                end
            end else begin
                nextMistake   = numMistake + 3'd1;
                nextMissValid = 1'b1;
                if (nextMistake == maxMistakes) begin
                    nextState = LOST;
                end
            end
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state      <= IDLE;
            numMistake <= '0;
            missValid  <= 1'b0;
        end else begin
            state      <= nextState;
            numMistake <= nextMistake;
            missValid  <= nextMissValid;
        end
    end

    always_ff @(posedge clk) begin
        missLetter <= guessBus.letter;    // only looked at while missValid is set.
    end

    assign status = '{state: state, revealed: revealed, numMistake: numMistake};
    assign miss   = '{valid: missValid, letter: missLetter};

    assert property (@(posedge clk) disable iff (!nRst)
        numMistake <= maxMistakes)
    else $error("roundJudge: numMistake %0d above limit", numMistake);

    // a loss is only ever reached through the sixth miss.
    assert property (@(posedge clk) disable iff (!nRst)
        (state == LOST) |-> (numMistake == maxMistakes))
    else $error("roundJudge: LOST with %0d mistakes", numMistake);

endmodule

// ==== logic/hostDisplay.sv ====
// Builds the two 16-column ASCII rows from the game status.
// The secret word is kept here as a separate copy taken on load.
// The miss history holds the six newest misses, newest first, and reads
// as underscores until it fills. Rows are registered and padded with spaces.
`timescale 1ns/10ps

module hostDisplay import hangmanPkg::*; (
    input  logic         clk,
    input  logic         nRst,
    input  wordLoad_t    wordBus,
    input  roundStatus_t status,
    input  missBeat_t    miss,
    output lcdRow_t      topRow,
    output lcdRow_t      bottomRow
);
    char_t [0:wordLen-1]     wordReg;
    char_t [0:maxMistakes-1] hist;
    char_t [0:maxMistakes-1] histShift;
    char_t [0:maxMistakes-1] histNext;
    lcdRow_t                 nextTop;
    lcdRow_t                 nextBottom;

    always_ff @(posedge clk) begin
        if (wordBus.load) begin
            wordReg <= wordBus.word;
        end
    end

    // the rows are built from histShift so a miss shows up in the same edge as the status.
    always_comb begin
        if (miss.valid) begin
            histShift = {miss.letter, hist[0:maxMistakes-2]};  // oldest entry drops off.
        end else begin
            histShift = hist;
        end
    end

    // a load clears the stored history. The row built in that edge still belongs to the
    // guess before the load.
    assign histNext = wordBus.load ? {maxMistakes{charBlank}} : histShift;

    // ########################################################################
    // row composition
    // ########################################################################
    always_comb begin
        nextTop    = {lcdCols{charSpace}};
        nextBottom = {lcdCols{charSpace}};
        case (status.state)
            PLAYING: begin
                for (int i = 0; i < wordLen; i++) begin
                    nextTop[wordCol+i] = status.revealed[i] ? wordReg[i] : charBlank;
                end
                for (int i = 0; i < maxMistakes; i++) begin
                    nextBottom[missCol+i] = histShift[i];
                end
            end
            WON: begin
                for (int i = 0; i < 3; i++) begin
                    nextTop[msgCol+i] = winText[i];
                end
                for (int i = 0; i < wordLen; i++) begin
                    nextBottom[wordCol+i] = wordReg[i];
                end
            end
            LOST: begin
                for (int i = 0; i < 4; i++) begin
                    nextTop[msgCol+i] = loseText[i];
                end
                for (int i = 0; i < wordLen; i++) begin
                    nextBottom[wordCol+i] = wordReg[i];    // reveal the word.
                end
            end
            default: begin
                nextTop    = {lcdCols{charSpace}};  // idle, nothing to show.
                nextBottom = {lcdCols{charSpace}};
            end
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            topRow    <= '0;
            bottomRow <= '0;
            hist      <= {maxMistakes{charBlank}};
        end else begin
            topRow    <= nextTop;
            bottomRow <= nextBottom;
            hist      <= histNext;
        end
    end

endmodule

// ==== logic/hangmanTop.sv ====
// Hangman core, from host strobes to the two display rows.
// Latency from a host strobe to the rows is three cycles, and guesses may
// follow each other every cycle. There is no back-pressure.
// Guesses arriving while no game runs are dropped.
`timescale 1ns/10ps

module hangmanTop import hangmanPkg::*; (
    input  logic                clk,
    input  logic                nRst,
    input  logic                loadWord,
    input  char_t [0:wordLen-1] word,
    input  logic                guessStrobe,
    input  char_t               guess,
    output lcdRow_t             topRow,
    output lcdRow_t             bottomRow
);
    wordLoad_t          wordBus;
    guessBeat_t         guessBus;
    roundStatus_t       status;
    missBeat_t          miss;
    logic [wordLen-1:0] hit;
    logic [wordLen-1:0] revealed;

    guessIntake intake (
        .clk         (clk),
        .nRst        (nRst),
        .loadWord    (loadWord),
        .word        (word),
        .guessStrobe (guessStrobe),
        .guess       (guess),
        .status      (status),
        .wordBus     (wordBus),
        .guessBus    (guessBus)
    );

    // one slot per position, each fed its own byte of the word.
    for (genvar i = 0; i < wordLen; i++) begin : gSlot
        letterSlot slot (
            .clk      (clk),
            .nRst     (nRst),
            .wordBus  (wordBus),
            .guessBus (guessBus),
            .secret   (wordBus.word[i]),
            .hit      (hit[i]),
            .revealed (revealed[i])
        );
    end

    roundJudge judge (
        .clk      (clk),
        .nRst     (nRst),
        .wordBus  (wordBus),
        .guessBus (guessBus),
        .hit      (hit),
        .revealed (revealed),
        .status   (status),
        .miss     (miss)
    );

    hostDisplay display (
        .clk       (clk),
        .nRst      (nRst),
        .wordBus   (wordBus),
        .status    (status),
        .miss      (miss),
        .topRow    (topRow),
        .bottomRow (bottomRow)
    );

endmodule

// ==== dv/hangmanTb.sv ====
// Testbench for the hangman core.
// A reference model follows the display rules from the same host strobes,
// and concurrent assertions compare both rows three cycles after each strobe.
// Random guesses are uppercase letters from a fixed seed.
`timescale 1ns/10ps

module hangmanTb import hangmanPkg::*; ();

    localparam int clkPeriod     = 8;
    localparam int resetCycles   = 10;
    localparam int numTests      = 6;
    localparam int cyclesPerTest = 40;    // longest test plus its drain, rounded up.
    localparam int drainCycles   = 5;

    logic                    clk;
    logic                    nRst;
    logic                    loadWord;
    char_t [0:wordLen-1]     word;
    logic                    guessStrobe;
    char_t                   guess;
    lcdRow_t                 topRow;
    lcdRow_t                 bottomRow;

    int                      seed;
    int                      errorCount;
    int                      passedTests;
    int                      failedTests;
    int                      testStartErrors;

    gameState_e              refState;
    char_t [0:wordLen-1]     refWord;
    logic [wordLen-1:0]      refShown;
    logic [wordLen-1:0]      shownNext;
    int                      refMisses;
    char_t [0:maxMistakes-1] refHist;
    lcdRow_t                 refTop;
    lcdRow_t                 refBottom;
    lcdRow_t                 pipeTop;
    lcdRow_t                 pipeBottom;
    lcdRow_t                 expTop;
    lcdRow_t                 expBottom;
    logic [2:0]              strobeAge;

    hangmanTop dut (
        .clk         (clk),
        .nRst        (nRst),
        .loadWord    (loadWord),
        .word        (word),
        .guessStrobe (guessStrobe),
        .guess       (guess),
        .topRow      (topRow),
        .bottomRow   (bottomRow)
    );

    always #(clkPeriod / 2) clk = ~clk;

    // ########################################################################
    // reference model
    // ########################################################################
    always @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            refState  <= IDLE;
            refWord   <= '0;
            refShown  <= '0;
            refMisses <= 0;
            refHist   <= {maxMistakes{charBlank}};
        end else if (loadWord) begin
            refState  <= PLAYING;  // a load wins over a guess in the same cycle.
            refWord   <= word;
            refShown  <= '0;
            refMisses <= 0;
            refHist   <= {maxMistakes{charBlank}};
        end else if (guessStrobe && refState == PLAYING) begin
            shownNext = refShown;
            for (int i = 0; i < wordLen; i++) begin
                if (refWord[i] == guess) begin
                    shownNext[i] = 1'b1;
                end
            end
            // a letter that uncovers nothing new is a miss, repeats included.
            if (shownNext != refShown) begin
                refShown <= shownNext;
                if (&shownNext) begin
                    refState <= WON;
                end
            end else begin
                refHist   <= {guess, refHist[0:maxMistakes-2]};
                refMisses <= refMisses + 1;
                if (refMisses + 1 == maxMistakes) begin
                    refState <= LOST;
                end
            end
        end
    end

    always_comb begin
        refTop    = {lcdCols{charSpace}};
        refBottom = {lcdCols{charSpace}};
        if (refState == PLAYING) begin
            for (int i = 0; i < wordLen; i++) begin
                refTop[5+i] = refShown[i] ? refWord[i] : charBlank;
            end
            for (int i = 0; i < maxMistakes; i++) begin
                refBottom[5+i] = refHist[i];    // newest miss at column 5.
            end
        end else if (refState == WON || refState == LOST) begin
            for (int i = 0; i < wordLen; i++) begin
                refBottom[5+i] = refWord[i];
            end
            if (refState == WON) begin
                refTop[6:8] = "Win";
            end else begin
                refTop[6:9] = "Lose";
            end
        end
    end

    // the model settles at the strobe edge, the DUT rows two edges later.
    always @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            pipeTop    <= '0;
            pipeBottom <= '0;
            expTop     <= '0;
            expBottom  <= '0;
            strobeAge  <= '0;
        end else begin
            pipeTop    <= refTop;
            pipeBottom <= refBottom;
            expTop     <= pipeTop;
            expBottom  <= pipeBottom;
            strobeAge  <= {strobeAge[1:0], loadWord || guessStrobe};
        end
    end

    // ########################################################################
    // checks
    // ########################################################################
    assert property (@(posedge clk) $rose(nRst) |-> (topRow == '0))
    else begin
        errorCount = errorCount + 1;
        $display("Fail topRow after reset expected %h got %h", 128'h0, $sampled(topRow));
    end

    assert property (@(posedge clk) $rose(nRst) |-> (bottomRow == '0))
    else begin
        errorCount = errorCount + 1;
        $display("Fail bottomRow after reset expected %h got %h", 128'h0, $sampled(bottomRow));
    end

    assert property (@(posedge clk) disable iff (!nRst)
        strobeAge[2] |-> (topRow == expTop))
    else begin
        errorCount = errorCount + 1;
        $display("Fail topRow expected %h got %h", $sampled(expTop), $sampled(topRow));
    end

    assert property (@(posedge clk) disable iff (!nRst)
        strobeAge[2] |-> (bottomRow == expBottom))
    else begin
        errorCount = errorCount + 1;
        $display("Fail bottomRow expected %h got %h", $sampled(expBottom), $sampled(bottomRow));
    end

    // ########################################################################
    // stimulus
    // ########################################################################
    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) nextCycle();
    endtask

    task automatic loadSecret(input char_t [0:wordLen-1] secret);
        loadWord = 1'b1;
        word     = secret;
        nextCycle();
        loadWord = 1'b0;
    endtask

    task automatic guessLetter(input char_t letter);
        guessStrobe = 1'b1;
        guess       = letter;
        nextCycle();
        guessStrobe = 1'b0;
    endtask

    task automatic loadWithGuess(input char_t [0:wordLen-1] secret, input char_t letter);
        loadWord    = 1'b1;
        word        = secret;
        guessStrobe = 1'b1;  // dropped, the load wins.
        guess       = letter;
        nextCycle();
        loadWord    = 1'b0;
        guessStrobe = 1'b0;
    endtask

    function automatic char_t randomLetter();
        return 8'h41 + 8'($unsigned($random(seed)) % 26);
    endfunction

    task automatic reportTest(input string name);
        int found;
        found = errorCount - testStartErrors;
        if (found == 0) begin
            passedTests = passedTests + 1;
            $display("test %s: ok", name);
        end else begin
            failedTests = failedTests + 1;
            $display("test %s: %0d errors", name, found);
        end
        testStartErrors = errorCount;
    endtask

    initial begin
        #((resetCycles + numTests * cyclesPerTest) * clkPeriod * 2);  // budget doubled.
        $display("watchdog: tests did not finish in time");
        $display("Something failed");
        $finish;
    end

    initial begin
        clk             = 1'b0;
        nRst            = 1'b0;
        loadWord        = 1'b0;
        word            = '0;
        guessStrobe     = 1'b0;
        guess           = '0;
        seed            = 27502;
        errorCount      = 0;
        passedTests     = 0;
        failedTests     = 0;
        testStartErrors = 0;
        repeat (resetCycles) @(posedge clk);
        #1;
        nRst = 1'b1;
        idle(2);

        loadSecret("CRANE");
        idle(drainCycles);
        reportTest("reset and load");

        loadSecret("LEVEL");
        guessLetter("L");
        guessLetter("E");
        idle(drainCycles);
        reportTest("correct guess");

        loadSecret("PLANT");
        guessLetter("X");
        guessLetter("Q");
        guessLetter("P");
        guessLetter("P");    // already shown, so it counts as a miss.
        guessLetter("Z");
        idle(drainCycles);
        reportTest("miss history");

        loadSecret("GHOST");
        guessLetter("G");
        guessLetter("H");
        guessLetter("O");
        guessLetter("S");
        guessLetter("T");
        guessLetter("Z");
        guessLetter("H");
        idle(drainCycles);
        reportTest("win");

        loadSecret("QUIRK");
        for (int i = 0; i < maxMistakes; i++) begin
            guessLetter(8'h41 + 8'(i));
        end
        guessLetter("Q");
        guessLetter("U");
        idle(drainCycles);
        reportTest("lose");

        // restart after a loss, then a random stream cut by a new word.
        loadSecret("JAZZY");
        for (int i = 0; i < 6; i++) begin
            guessLetter(randomLetter());
        end
        loadWithGuess("ROBIN", randomLetter());
        for (int i = 0; i < 6; i++) begin
            guessLetter(randomLetter());
        end
        loadSecret("ABCDE");
        for (int i = 0; i < wordLen; i++) begin
            guessLetter(8'h41 + 8'(i));
        end
        guessLetter("A");
        guessLetter("Q");
        loadSecret("HOUSE");
        idle(drainCycles);
        reportTest("game over and restart");

        $display("tests %0d, passed %0d, failed %0d, assertion errors %0d",
                 numTests, passedTests, failedTests, errorCount);
        if (errorCount == 0 && failedTests == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
logic/hangmanPkg.sv
logic/guessIntake.sv
logic/letterSlot.sv
logic/roundJudge.sv
logic/hostDisplay.sv
logic/hangmanTop.sv
dv/hangmanTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the hangman testbench with Verilator and runs it.
# Exits 0 only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f compile.f --top-module hangmanTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/VhangmanTb)
simStatus=$?
printf '%s\n' "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if printf '%s\n' "$simOut" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1
